//--- flist.f
verilog/sat_bin_pkg.sv
verilog/bin_mem_if.sv
verilog/engine_load_if.sv
verilog/bin_store.sv
verilog/load_bin.sv
verilog/local_arrays.sv
verilog/bin_loader_top.sv
bench/tb_bin_loader.sv

//--- Bender.yml
package:
  name: sat_bin_loader

sources:
  - verilog/sat_bin_pkg.sv
  - verilog/bin_mem_if.sv
  - verilog/engine_load_if.sv
  - verilog/bin_store.sv
  - verilog/load_bin.sv
  - verilog/local_arrays.sv
  - verilog/bin_loader_top.sv
  - target: simulation
    files:
      - bench/tb_bin_loader.sv

//--- bench/tb_bin_loader.sv
`timescale 1ns/1ns

module tb_bin_loader;
    import sat_bin_pkg::*;

    localparam int MEM_DEPTH = 512;
    localparam int MAX_WAIT  = 200;

    logic                      clk;
    logic                      rst;
    logic                      start_load_i;
    logic [WIDTH_BIN_ID-1:0]   request_bin_i;
    logic [WIDTH_LVL-1:0]      cur_lvl_i;
    logic                      pre_wr_en_i;
    mem_sel_e                  pre_sel_i;
    logic [ADDR_WIDTH_BIN-1:0] pre_addr_i;
    logic [WIDTH_PRE_DATA-1:0] pre_data_i;
    mem_sel_e                  rd_sel_i;
    logic [2:0]                rd_idx_i;
    logic                      busy_o;
    logic                      done_load_o;
    logic [WIDTH_LVL-1:0]      base_lvl_o;
    logic                      base_lvl_valid_o;
    logic [WIDTH_PRE_DATA-1:0] rd_data_o;

    // reference copies of the four rams
    logic [WIDTH_CLAUSE-1:0]    clause_ref [MEM_DEPTH];
    logic [WIDTH_VAR_ID-1:0]    var_id_ref [MEM_DEPTH];
    logic [WIDTH_VAR_STATE-1:0] var_st_ref [MEM_DEPTH];
    logic [WIDTH_LVL_STATE-1:0] lvl_st_ref [MEM_DEPTH];

    int errors;
    int timeouts;
    int done_count;

    bin_loader_top DUT (
        .clk              (clk),
        .rst              (rst),
        .start_load_i     (start_load_i),
        .request_bin_i    (request_bin_i),
        .cur_lvl_i        (cur_lvl_i),
        .pre_wr_en_i      (pre_wr_en_i),
        .pre_sel_i        (pre_sel_i),
        .pre_addr_i       (pre_addr_i),
        .pre_data_i       (pre_data_i),
        .rd_sel_i         (rd_sel_i),
        .rd_idx_i         (rd_idx_i),
        .busy_o           (busy_o),
        .done_load_o      (done_load_o),
        .base_lvl_o       (base_lvl_o),
        .base_lvl_valid_o (base_lvl_valid_o),
        .rd_data_o        (rd_data_o)
    );

    always
    begin
        #5 clk = ~clk;
    end

    // done is stable at the falling edge
    always @(negedge clk)
    begin
        if (done_load_o === 1'b1)
            done_count++;
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        if (actual !== expected)
        begin
            $display("Error at %0t ns: %s, got %h, expected %h", $time, msg, actual, expected);
            errors++;
        end
    endtask

    task automatic preload_word(input mem_sel_e sel, input int addr,
                                input logic [WIDTH_PRE_DATA-1:0] data);
        @(posedge clk);
        #1;
        pre_wr_en_i = 1'b1;
        pre_sel_i   = sel;
        pre_addr_i  = addr[ADDR_WIDTH_BIN-1:0];
        pre_data_i  = data;
        @(posedge clk);
        #1;
        pre_wr_en_i = 1'b0;
        case (sel)
            SEL_CLAUSE:    clause_ref[addr] = data[WIDTH_CLAUSE-1:0];
            SEL_VAR_ID:    var_id_ref[addr] = data[WIDTH_VAR_ID-1:0];
            SEL_VAR_STATE: var_st_ref[addr] = data[WIDTH_VAR_STATE-1:0];
            default:       lvl_st_ref[addr] = data[WIDTH_LVL_STATE-1:0];
        endcase
    endtask

    task automatic preload_all();
        for (int a = 0; a < MEM_DEPTH; a++)
        begin
            preload_word(SEL_CLAUSE, a, $urandom);
            preload_word(SEL_VAR_ID, a, $urandom);
            preload_word(SEL_VAR_STATE, a, $urandom);
            preload_word(SEL_LVL_STATE, a, $urandom);
        end
    endtask

    function automatic logic [WIDTH_PRE_DATA-1:0] lvl_word(input logic [WIDTH_BIN_ID-1:0] bin);
        logic [LVL_BIN_LSB-1:0] low;
        low = $urandom;
        return {bin, low};
    endfunction

    // walk down from cur while the bin field matches
    function automatic int ref_base(input int bin, input int cur);
        int lvl;
        int base;
        lvl  = cur;
        base = -1;
        while (base < 0)
        begin
            if (int'(lvl_st_ref[lvl][LVL_BIN_MSB:LVL_BIN_LSB]) == bin)
            begin
                if (lvl == 0)
                    base = 0;
                else
                    lvl--;
            end
            else
                base = (lvl + 1 > cur) ? cur : lvl + 1;
        end
        return base;
    endfunction

    task automatic issue_start(input int bin, input int cur);
        @(posedge clk);
        #1;
        start_load_i  = 1'b1;
        request_bin_i = bin[WIDTH_BIN_ID-1:0];
        cur_lvl_i     = cur[WIDTH_LVL-1:0];
        @(posedge clk);
        #1;
        start_load_i  = 1'b0;
    endtask

    task automatic wait_done(input string what);
        int cycles;
        cycles = 0;
        while (done_load_o !== 1'b1 && cycles < MAX_WAIT)
        begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (done_load_o !== 1'b1)
        begin
            $display("Timeout: no done pulse within %0d cycles for %s", MAX_WAIT, what);
            timeouts++;
        end
    endtask

    task automatic read_slot(input mem_sel_e sel, input int idx,
                             output logic [31:0] data);
        @(posedge clk);
        #1;
        rd_sel_i = sel;
        rd_idx_i = idx[2:0];
        #1;
        data = 32'(rd_data_o);
    endtask

    task automatic check_clause_slots(input int bin);
        logic [31:0] got;
        for (int k = 0; k < NUM_CLAUSES_A_BIN; k++)
        begin
            read_slot(SEL_CLAUSE, k, got);
            check_value(got, 32'(clause_ref[(bin * 8 + k) % MEM_DEPTH]),
                        $sformatf("clause slot %0d of bin %0d", k, bin));
        end
    endtask

    task automatic check_var_state_slots(input int bin);
        logic [31:0] got;
        logic [31:0] exp;
        for (int k = 0; k < NUM_VARS_A_BIN; k++)
        begin
            exp = 32'(var_st_ref[var_id_ref[(bin * 8 + k) % MEM_DEPTH]]);
            read_slot(SEL_VAR_STATE, k, got);
            check_value(got, exp, $sformatf("var state slot %0d of bin %0d", k, bin));
            // var id select reads the same state slots
            read_slot(SEL_VAR_ID, k, got);
            check_value(got, exp, $sformatf("var id select slot %0d of bin %0d", k, bin));
        end
    endtask

    task automatic check_lvl_slots(input int bin, input int cur);
        logic [31:0] got;
        int          base;
        base = ref_base(bin, cur);
        check_value(base_lvl_valid_o, 1, $sformatf("base valid for bin %0d", bin));
        check_value(base_lvl_o, base, $sformatf("base level for bin %0d", bin));
        for (int k = 0; k < NUM_LVLS_A_BIN; k++)
        begin
            read_slot(SEL_LVL_STATE, k, got);
            check_value(got, 32'(lvl_st_ref[(base + k) % MEM_DEPTH]),
                        $sformatf("level slot %0d of bin %0d", k, bin));
        end
    endtask

    task automatic test_reset_state();
        logic [31:0] got;
        check_value(busy_o, 0, "busy after reset");
        check_value(done_load_o, 0, "done after reset");
        check_value(base_lvl_valid_o, 0, "base valid after reset");
        for (int k = 0; k < 8; k++)
        begin
            read_slot(SEL_CLAUSE, k, got);
            check_value(got, 0, $sformatf("clause slot %0d after reset", k));
            read_slot(SEL_VAR_STATE, k, got);
            check_value(got, 0, $sformatf("var state slot %0d after reset", k));
            read_slot(SEL_LVL_STATE, k, got);
            check_value(got, 0, $sformatf("level slot %0d after reset", k));
        end
    endtask

    task automatic test_clause_load(input int bin, input int cur);
        issue_start(bin, cur);
        wait_done("clause load");
        check_clause_slots(bin);
    endtask

    task automatic test_var_state_load(input int bin, input int cur);
        issue_start(bin, cur);
        wait_done("var state load");
        check_var_state_slots(bin);
    endtask

    task automatic test_base_level_search();
        // levels 5..9 decided by bin 13, level 4 by another bin
        for (int l = 5; l <= 9; l++)
            preload_word(SEL_LVL_STATE, l, lvl_word(13));
        preload_word(SEL_LVL_STATE, 4, lvl_word(14));
        issue_start(13, 9);
        wait_done("base search stopping at level 5");
        check_value(base_lvl_o, 5, "base level with mismatch at 4");
        check_lvl_slots(13, 9);

        for (int l = 0; l <= 6; l++)
            preload_word(SEL_LVL_STATE, l, lvl_word(30));
        issue_start(30, 6);
        wait_done("base search down to level 0");
        check_value(base_lvl_o, 0, "base level with match down to 0");
        check_lvl_slots(30, 6);
    endtask

    task automatic test_back_to_back();
        done_count = 0;
        issue_start(21, 3);
        repeat (3) @(posedge clk);
        #1;
        check_value(busy_o, 1, "busy during first load");
        // this one lands while busy and must be dropped
        issue_start(7, 2);
        wait_done("first of two loads");
        check_clause_slots(21);
        check_var_state_slots(21);
        check_lvl_slots(21, 3);
        issue_start(40, 5);
        wait_done("second of two loads");
        check_clause_slots(40);
        check_var_state_slots(40);
        check_lvl_slots(40, 5);
        @(posedge clk);
        #1;
        check_value(done_count, 2, "done pulses for two accepted starts");
    endtask

    initial
    begin
        clk           = 1'b0;
        rst           = 1'b1;
        start_load_i  = 1'b0;
        request_bin_i = '0;
        cur_lvl_i     = '0;
        pre_wr_en_i   = 1'b0;
        pre_sel_i     = SEL_CLAUSE;
        pre_addr_i    = '0;
        pre_data_i    = '0;
        rd_sel_i      = SEL_CLAUSE;
        rd_idx_i      = '0;
        errors        = 0;
        timeouts      = 0;
        done_count    = 0;
        void'($urandom(83599));

        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        #1;

        test_reset_state();
        preload_all();
        test_clause_load(5, 12);
        test_var_state_load(17, 20);
        test_base_level_search();
        test_back_to_back();

        $display("Finished with %0d errors and %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

//--- verilog/bin_loader_top.sv
`timescale 1ns/1ns

module bin_loader_top
(
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   start_load_i,
    input  logic [sat_bin_pkg::WIDTH_BIN_ID-1:0]   request_bin_i,
    input  logic [sat_bin_pkg::WIDTH_LVL-1:0]      cur_lvl_i,
    input  logic                                   pre_wr_en_i,
    input  sat_bin_pkg::mem_sel_e                  pre_sel_i,
    input  logic [sat_bin_pkg::ADDR_WIDTH_BIN-1:0] pre_addr_i,
    input  logic [sat_bin_pkg::WIDTH_PRE_DATA-1:0] pre_data_i,
    input  sat_bin_pkg::mem_sel_e                  rd_sel_i,
    input  logic [2:0]                             rd_idx_i,
    output logic                                   busy_o,
    output logic                                   done_load_o,
    output logic [sat_bin_pkg::WIDTH_LVL-1:0]      base_lvl_o,
    output logic                                   base_lvl_valid_o,
    output logic [sat_bin_pkg::WIDTH_PRE_DATA-1:0] rd_data_o
);

    bin_mem_if     mem_bus ();
    engine_load_if eng_bus ();

    bin_store u_store (
        .clk         (clk),
        .rst         (rst),
        .pre_wr_en_i (pre_wr_en_i),
        .pre_sel_i   (pre_sel_i),
        .pre_addr_i  (pre_addr_i),
        .pre_data_i  (pre_data_i),
        .mem         (mem_bus.store)
    );

    load_bin u_loader (
        .clk               (clk),
        .rst               (rst),
        .start_load_i      (start_load_i),
        .request_bin_num_i (request_bin_i),
        .cur_lvl_i         (cur_lvl_i),
        .apply_load_o      (busy_o),
        .done_load_o       (done_load_o),
        .base_lvl_o        (base_lvl_o),
        .base_lvl_en_o     (base_lvl_valid_o),
        .mem               (mem_bus.loader),
        .eng               (eng_bus.loader)
    );

    local_arrays u_arrays (
        .clk       (clk),
        .rst       (rst),
        .eng       (eng_bus.arrays),
        .rd_sel_i  (rd_sel_i),
        .rd_idx_i  (rd_idx_i),
        .rd_data_o (rd_data_o)
    );

endmodule

//--- verilog/local_arrays.sv
`timescale 1ns/1ns

module local_arrays
(
    input  logic                                   clk,
    input  logic                                   rst,
    engine_load_if.arrays                          eng,
    input  sat_bin_pkg::mem_sel_e                  rd_sel_i,
    input  logic [2:0]                             rd_idx_i,
    output logic [sat_bin_pkg::WIDTH_PRE_DATA-1:0] rd_data_o
);
    import sat_bin_pkg::*;

    logic [WIDTH_CLAUSE-1:0]    clause_q [NUM_CLAUSES_A_BIN];
    logic [WIDTH_VAR_STATE-1:0] var_st_q [NUM_VARS_A_BIN];
    logic [WIDTH_LVL_STATE-1:0] lvl_st_q [NUM_LVLS_A_BIN];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            clause_q <= '{default: '0};
            var_st_q <= '{default: '0};
            lvl_st_q <= '{default: '0};
        end
        else
        begin
            for (int k = 0; k < NUM_CLAUSES_A_BIN; k++)
            begin
                if (eng.wr_clause[k])
                    clause_q[k] <= eng.clause;
            end
            for (int k = 0; k < NUM_VARS_A_BIN; k++)
            begin
                if (eng.wr_var_state[k])
                    var_st_q[k] <= eng.var_state;
            end
            for (int k = 0; k < NUM_LVLS_A_BIN; k++)
            begin
                if (eng.wr_lvl_state[k])
                    lvl_st_q[k] <= eng.lvl_state;
            end
        end
    end

    // var ids are not kept locally, so both var selects read the state slots
    always_comb
    begin
        case (rd_sel_i)
            SEL_CLAUSE:    rd_data_o = WIDTH_PRE_DATA'(clause_q[rd_idx_i]);
            SEL_VAR_ID:    rd_data_o = WIDTH_PRE_DATA'(var_st_q[rd_idx_i]);
            SEL_VAR_STATE: rd_data_o = WIDTH_PRE_DATA'(var_st_q[rd_idx_i]);
            default:       rd_data_o = WIDTH_PRE_DATA'(lvl_st_q[rd_idx_i]);
        endcase
    end

endmodule

//--- verilog/load_bin.sv
`timescale 1ns/1ns

module load_bin
(
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  start_load_i,
    input  logic [sat_bin_pkg::WIDTH_BIN_ID-1:0]  request_bin_num_i,
    input  logic [sat_bin_pkg::WIDTH_LVL-1:0]     cur_lvl_i,
    output logic                                  apply_load_o,
    output logic                                  done_load_o,
    output logic [sat_bin_pkg::WIDTH_LVL-1:0]     base_lvl_o,
    output logic                                  base_lvl_en_o,
    bin_mem_if.loader                             mem,
    engine_load_if.loader                         eng
);
    import sat_bin_pkg::*;

    load_state_e                          state_q;
    load_state_e                          state_d;
    logic [WIDTH_BIN_ID-1:0]              req_bin_q;
    logic [WIDTH_LVL-1:0]                 cur_lvl_q;
    logic [WIDTH_LVL-1:0]                 lvl_ptr_q;
    logic [$clog2(NUM_CLAUSES_A_BIN)-1:0] fetch_cnt_q;
    logic [$clog2(NUM_LVLS_A_BIN)-1:0]    lvl_cnt_q;
    logic [ADDR_WIDTH_BIN-1:0]            bin_base;
    logic                                 fetch_first;
    logic                                 fetch_first_q;
    logic                                 lvl_first;
    logic                                 bin_match;
    logic                                 drain_busy;
    logic [NUM_CLAUSES_A_BIN-1:0]         wr_c_q;
    logic [NUM_VARS_A_BIN-1:0]            wr_vs_q;
    logic [NUM_LVLS_A_BIN-1:0]            wr_ls_q;

    // bin b starts at entry b*8
    assign bin_base    = ADDR_WIDTH_BIN'(req_bin_q) << $clog2(NUM_CLAUSES_A_BIN);
    assign fetch_first = (state_q == FETCH) && (fetch_cnt_q == '0);
    assign lvl_first   = (state_q == LVL_LOAD) && (lvl_cnt_q == '0);
    assign bin_match   = (mem.data_ls[LVL_BIN_MSB:LVL_BIN_LSB] == req_bin_q);

    // strobes still to fire after this cycle
    assign drain_busy = fetch_first_q
                      | (|wr_c_q[NUM_CLAUSES_A_BIN-2:0])
                      | (|wr_vs_q[NUM_VARS_A_BIN-2:0])
                      | (|wr_ls_q[NUM_LVLS_A_BIN-2:0]);

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            IDLE:
                if (start_load_i)
                    state_d = FETCH;
            FETCH:
                if (fetch_cnt_q == $clog2(NUM_CLAUSES_A_BIN)'(NUM_CLAUSES_A_BIN - 1))
                    state_d = SEARCH_ISSUE;
            SEARCH_ISSUE:
                state_d = SEARCH_CHECK;
            SEARCH_CHECK:
                if (bin_match && lvl_ptr_q != '0)
                    state_d = SEARCH_ISSUE;
                else
                    state_d = LVL_LOAD;
            LVL_LOAD:
                if (lvl_cnt_q == $clog2(NUM_LVLS_A_BIN)'(NUM_LVLS_A_BIN - 1))
                    state_d = DRAIN;
            DRAIN:
                if (!drain_busy)
                    state_d = DONE;
            DONE:
                state_d = IDLE;
            default:
                state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q     <= IDLE;
            fetch_cnt_q <= '0;
            lvl_cnt_q   <= '0;
        end
        else
        begin
            state_q     <= state_d;
            fetch_cnt_q <= (state_q == FETCH) ? fetch_cnt_q + 1'b1 : '0;
            lvl_cnt_q   <= (state_q == LVL_LOAD) ? lvl_cnt_q + 1'b1 : '0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (state_q == IDLE && start_load_i)
        begin
            req_bin_q <= request_bin_num_i;
            cur_lvl_q <= cur_lvl_i;
        end
    end

    // walk down the level list while the deciding bin matches
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            lvl_ptr_q     <= '0;
            base_lvl_o    <= '0;
            base_lvl_en_o <= 1'b0;
        end
        else if (state_q == IDLE && start_load_i)
        begin
            lvl_ptr_q     <= cur_lvl_i;
            base_lvl_en_o <= 1'b0;
        end
        else if (state_q == SEARCH_CHECK)
        begin
            if (bin_match && lvl_ptr_q != '0)
                lvl_ptr_q <= lvl_ptr_q - 1'b1;
            else
            begin
                base_lvl_en_o <= 1'b1;
                if (bin_match)
                    base_lvl_o <= '0;
                else if (lvl_ptr_q == cur_lvl_q)
                    base_lvl_o <= cur_lvl_q;
                else
                    base_lvl_o <= lvl_ptr_q + 1'b1;
            end
        end
    end

    // one-hot strobes follow the read latency, var state is two deep
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            fetch_first_q <= 1'b0;
            wr_c_q        <= '0;
            wr_vs_q       <= '0;
            wr_ls_q       <= '0;
        end
        else
        begin
            fetch_first_q <= fetch_first;
            wr_c_q        <= fetch_first ? NUM_CLAUSES_A_BIN'(1) : wr_c_q << 1;
            wr_vs_q       <= fetch_first_q ? NUM_VARS_A_BIN'(1) : wr_vs_q << 1;
            wr_ls_q       <= lvl_first ? NUM_LVLS_A_BIN'(1) : wr_ls_q << 1;
        end
    end

    assign mem.addr_c  = bin_base + ADDR_WIDTH_BIN'(fetch_cnt_q);
    assign mem.addr_v  = bin_base + ADDR_WIDTH_BIN'(fetch_cnt_q);
    // var id goes straight back out as the state address
    assign mem.addr_vs = mem.data_v;
    assign mem.addr_ls = (state_q == LVL_LOAD) ? base_lvl_o + WIDTH_LVL'(lvl_cnt_q)
                                               : lvl_ptr_q;

    assign eng.wr_clause    = wr_c_q;
    assign eng.clause       = mem.data_c;
    assign eng.wr_var_state = wr_vs_q;
    assign eng.var_state    = mem.data_vs;
    assign eng.wr_lvl_state = wr_ls_q;
    assign eng.lvl_state    = mem.data_ls;

    assign apply_load_o = (state_q != IDLE);
    assign done_load_o  = (state_q == DONE);

endmodule

//--- verilog/bin_store.sv
`timescale 1ns/1ns

module bin_store
(
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    pre_wr_en_i,
    input  sat_bin_pkg::mem_sel_e                   pre_sel_i,
    input  logic [sat_bin_pkg::ADDR_WIDTH_BIN-1:0]  pre_addr_i,
    input  logic [sat_bin_pkg::WIDTH_PRE_DATA-1:0]  pre_data_i,
    bin_mem_if.store                                mem
);
    import sat_bin_pkg::*;

    logic [WIDTH_CLAUSE-1:0]    clause_ram [2**ADDR_WIDTH_BIN];
    logic [WIDTH_VAR_ID-1:0]    var_id_ram [2**ADDR_WIDTH_BIN];
    logic [WIDTH_VAR_STATE-1:0] var_st_ram [2**WIDTH_VAR_ID];
    logic [WIDTH_LVL_STATE-1:0] lvl_st_ram [2**WIDTH_LVL];

    // preload port, narrow rams keep the low bits
    always_ff @(posedge clk)
    begin
        if (pre_wr_en_i && pre_sel_i == SEL_CLAUSE)
            clause_ram[pre_addr_i] <= pre_data_i[WIDTH_CLAUSE-1:0];
    end

    always_ff @(posedge clk)
    begin
        if (pre_wr_en_i && pre_sel_i == SEL_VAR_ID)
            var_id_ram[pre_addr_i] <= pre_data_i[WIDTH_VAR_ID-1:0];
    end

    always_ff @(posedge clk)
    begin
        if (pre_wr_en_i && pre_sel_i == SEL_VAR_STATE)
            var_st_ram[pre_addr_i] <= pre_data_i[WIDTH_VAR_STATE-1:0];
    end

    always_ff @(posedge clk)
    begin
        if (pre_wr_en_i && pre_sel_i == SEL_LVL_STATE)
            lvl_st_ram[pre_addr_i] <= pre_data_i[WIDTH_LVL_STATE-1:0];
    end

    // registered read ports
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            mem.data_c  <= '0;
            mem.data_v  <= '0;
            mem.data_vs <= '0;
            mem.data_ls <= '0;
        end
        else
        begin
            mem.data_c  <= clause_ram[mem.addr_c];
            mem.data_v  <= var_id_ram[mem.addr_v];
            mem.data_vs <= var_st_ram[mem.addr_vs];
            mem.data_ls <= lvl_st_ram[mem.addr_ls];
        end
    end

endmodule

//--- verilog/engine_load_if.sv
`timescale 1ns/1ns

interface engine_load_if;
    import sat_bin_pkg::*;

    // one-hot slot strobes, each with its data word
    logic [NUM_CLAUSES_A_BIN-1:0] wr_clause;
    logic [WIDTH_CLAUSE-1:0]      clause;
    logic [NUM_VARS_A_BIN-1:0]    wr_var_state;
    logic [WIDTH_VAR_STATE-1:0]   var_state;
    logic [NUM_LVLS_A_BIN-1:0]    wr_lvl_state;
    logic [WIDTH_LVL_STATE-1:0]   lvl_state;

    modport loader (output wr_clause, clause, wr_var_state, var_state,
                           wr_lvl_state, lvl_state);
    modport arrays (input  wr_clause, clause, wr_var_state, var_state,
                           wr_lvl_state, lvl_state);

endinterface

//--- verilog/bin_mem_if.sv
`timescale 1ns/1ns

interface bin_mem_if;
    import sat_bin_pkg::*;

    logic [ADDR_WIDTH_BIN-1:0]  addr_c;
    logic [ADDR_WIDTH_BIN-1:0]  addr_v;
    logic [WIDTH_VAR_ID-1:0]    addr_vs;
    logic [WIDTH_LVL-1:0]       addr_ls;

    // one cycle behind the address
    logic [WIDTH_CLAUSE-1:0]    data_c;
    logic [WIDTH_VAR_ID-1:0]    data_v;
    logic [WIDTH_VAR_STATE-1:0] data_vs;
    logic [WIDTH_LVL_STATE-1:0] data_ls;

    modport loader (output addr_c, addr_v, addr_vs, addr_ls,
                    input  data_c, data_v, data_vs, data_ls);
    modport store  (input  addr_c, addr_v, addr_vs, addr_ls,
                    output data_c, data_v, data_vs, data_ls);

endinterface

//--- verilog/sat_bin_pkg.sv
package sat_bin_pkg;

    // bin geometry
    localparam int NUM_CLAUSES_A_BIN = 8;
    localparam int NUM_VARS_A_BIN    = 8;
    localparam int NUM_LVLS_A_BIN    = 8;

    localparam int WIDTH_CLAUSE      = NUM_VARS_A_BIN * 2;
    localparam int WIDTH_BIN_ID      = 10;
    localparam int WIDTH_VAR_ID      = 9;
    localparam int WIDTH_VAR_STATE   = 30;
    localparam int WIDTH_LVL         = 9;
    localparam int WIDTH_LVL_STATE   = 30;
    localparam int ADDR_WIDTH_BIN    = 9;
    localparam int WIDTH_PRE_DATA    = 30;

    // level state word: deciding bin on top, backtrack flag at bit 0
    localparam int LVL_BIN_MSB       = 29;
    localparam int LVL_BIN_LSB       = 20;
    localparam int LVL_HAS_BKT       = 0;

    typedef enum logic [2:0] {
        IDLE, FETCH, SEARCH_ISSUE, SEARCH_CHECK, LVL_LOAD, DRAIN, DONE
    } load_state_e;

    typedef enum logic [1:0] {
        SEL_CLAUSE, SEL_VAR_ID, SEL_VAR_STATE, SEL_LVL_STATE
    } mem_sel_e;

endpackage
